/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --assert
TOP ?= tb_alu_reg_iq
FILELIST ?= list.f
PASS_TEXT = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

/* alu_reg_iq.sv */
// ALU register-register issue queue
// Holds up to 8 ops in age order with the oldest at entry 0. Wakes operands
// from the banked writeback bus, issues the oldest ready op, compacts the
// remaining entries and appends newly dispatched ops at the tail
`timescale 1ns/1ps

module alu_reg_iq (
	input logic CLK,
	input logic nRST,

	// Dispatch by way
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input core_types_pkg::alu_dispatch_t [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_ready_by_way,

	// ALU pipeline feedback
	input logic pipeline_ready,

	// Writeback bus by bank
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

	// Issue and register read
	output core_types_pkg::alu_issue_t issue,
	output core_types_pkg::prf_req_t PRF_req
);

	core_types_pkg::iq_entry_t [core_types_pkg::IQ_ENTRIES-1:0] entries;
	core_types_pkg::iq_count_t occupancy;

	logic [core_types_pkg::IQ_ENTRIES-1:0] A_wake_by_entry;
	logic [core_types_pkg::IQ_ENTRIES-1:0] B_wake_by_entry;
	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_A_wake_by_way;
	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_B_wake_by_way;

	logic issue_fire;
	logic [core_types_pkg::LOG_IQ_ENTRIES-1:0] issue_index;

	core_types_pkg::iq_entry_t [core_types_pkg::IQ_ENTRIES-1:0] new_entry_by_slot;
	core_types_pkg::iq_count_t new_count;
	core_types_pkg::iq_entry_t [core_types_pkg::IQ_ENTRIES-1:0] woken_entries;
	core_types_pkg::iq_entry_t [core_types_pkg::IQ_ENTRIES-1:0] next_entries;

	// True when the bank of pr broadcasts its upper bits this cycle
	function automatic logic wb_match(
		input core_types_pkg::pr_t pr,
		input logic [core_types_pkg::PRF_BANK_COUNT-1:0] wb_valid,
		input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_upper
	);
		core_types_pkg::bank_t bank;
		core_types_pkg::upper_pr_t upper;
		bank = pr[core_types_pkg::LOG_PRF_BANK_COUNT-1:0];
		upper = pr[core_types_pkg::LOG_PR_COUNT-1:core_types_pkg::LOG_PRF_BANK_COUNT];
		return wb_valid[bank] && (wb_upper[bank] == upper);
	endfunction

	// ----------------------------------------
	// Wakeup match
	always_comb begin
		for (int e = 0; e < core_types_pkg::IQ_ENTRIES; e++) begin
			A_wake_by_entry[e] = wb_match(entries[e].A_PR,
				WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
			B_wake_by_entry[e] = wb_match(entries[e].B_PR,
				WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
		end
		for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
			dispatch_A_wake_by_way[w] = wb_match(dispatch_by_way[w].A_PR,
				WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
			dispatch_B_wake_by_way[w] = wb_match(dispatch_by_way[w].B_PR,
				WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
		end
	end

	// ----------------------------------------
	// Dispatch and select
	alu_reg_iq_dispatch dispatch_i (
		.occupancy(occupancy),
		.issue_fire(issue_fire),
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_by_way(dispatch_by_way),
		.dispatch_A_wake_by_way(dispatch_A_wake_by_way),
		.dispatch_B_wake_by_way(dispatch_B_wake_by_way),
		.dispatch_ready_by_way(dispatch_ready_by_way),
		.new_entry_by_slot(new_entry_by_slot),
		.new_count(new_count)
	);

	alu_reg_iq_select select_i (
		.entries(entries),
		.A_wake_by_entry(A_wake_by_entry),
		.B_wake_by_entry(B_wake_by_entry),
		.pipeline_ready(pipeline_ready),
		.issue_fire(issue_fire),
		.issue_index(issue_index),
		.issue(issue),
		.PRF_req(PRF_req)
	);

	// ----------------------------------------
	// Next state: wakeup, compaction, append
	always_comb begin
		for (int e = 0; e < core_types_pkg::IQ_ENTRIES; e++) begin
			woken_entries[e] = entries[e];
			woken_entries[e].A_ready = entries[e].A_ready | A_wake_by_entry[e];
			woken_entries[e].B_ready = entries[e].B_ready | B_wake_by_entry[e];
		end
	end

	always_comb begin
		// Entries at and above the issued one move down by one
		for (int e = 0; e < core_types_pkg::IQ_ENTRIES - 1; e++) begin
			if (issue_fire && e >= int'(issue_index)) begin
				next_entries[e] = woken_entries[e+1];
			end else begin
				next_entries[e] = woken_entries[e];
			end
		end
		if (issue_fire) begin
			next_entries[core_types_pkg::IQ_ENTRIES-1] = '0;
		end else begin
			next_entries[core_types_pkg::IQ_ENTRIES-1] =
				woken_entries[core_types_pkg::IQ_ENTRIES-1];
		end
		// New ops land in slots that are empty after compaction
		for (int s = 0; s < core_types_pkg::IQ_ENTRIES; s++) begin
			if (new_entry_by_slot[s].valid) begin
				next_entries[s] = new_entry_by_slot[s];
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			entries <= '0;
			occupancy <= '0;
		end else begin
			entries <= next_entries;
			occupancy <= new_count;
		end
	end

endmodule

/* alu_reg_iq_dispatch.sv */
// ALU issue queue dispatch placement
// Turns occupancy into per-way ready feedback and packs the accepted ops
// into the free tail slots, in way order, after this cycle's issue removal
`timescale 1ns/1ps

module alu_reg_iq_dispatch (
	input core_types_pkg::iq_count_t occupancy,
	input logic issue_fire,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input core_types_pkg::alu_dispatch_t [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_by_way,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_A_wake_by_way,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_B_wake_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_ready_by_way,
	output core_types_pkg::iq_entry_t [core_types_pkg::IQ_ENTRIES-1:0] new_entry_by_slot,
	output core_types_pkg::iq_count_t new_count
);

	core_types_pkg::iq_count_t free_count;
	core_types_pkg::iq_count_t base_slot;
	logic [core_types_pkg::DISPATCH_WAYS-1:0] place_by_way;
	core_types_pkg::iq_count_t [core_types_pkg::DISPATCH_WAYS-1:0] slot_by_way;
	core_types_pkg::iq_entry_t [core_types_pkg::DISPATCH_WAYS-1:0] entry_by_way;

	// Ready feedback depends on start-of-cycle occupancy only
	assign free_count = core_types_pkg::iq_count_t'(core_types_pkg::IQ_ENTRIES) - occupancy;
	assign base_slot = occupancy - core_types_pkg::iq_count_t'(issue_fire);

	always_comb begin
		for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
			dispatch_ready_by_way[w] = free_count > core_types_pkg::iq_count_t'(w);
			place_by_way[w] = dispatch_by_way[w].valid & dispatch_attempt_by_way[w]
				& dispatch_ready_by_way[w];
		end
	end

	// Prefix count over accepted ways gives each op its slot
	always_comb begin
		core_types_pkg::iq_count_t running;
		running = base_slot;
		for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
			slot_by_way[w] = running;
			running = running + core_types_pkg::iq_count_t'(place_by_way[w]);
		end
		new_count = running;
	end

	// Entry image per way, with same-cycle wakeup merged in
	always_comb begin
		for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
			entry_by_way[w].valid = 1'b1;
			entry_by_way[w].op = dispatch_by_way[w].op;
			entry_by_way[w].A_PR = dispatch_by_way[w].A_PR;
			entry_by_way[w].A_ready = dispatch_by_way[w].A_ready | dispatch_A_wake_by_way[w];
			entry_by_way[w].B_PR = dispatch_by_way[w].B_PR;
			entry_by_way[w].B_ready = dispatch_by_way[w].B_ready | dispatch_B_wake_by_way[w];
			entry_by_way[w].dest_PR = dispatch_by_way[w].dest_PR;
			entry_by_way[w].ROB_index = dispatch_by_way[w].ROB_index;
		end
	end

	// Only placed slots come out valid
	always_comb begin
		new_entry_by_slot = '0;
		for (int s = 0; s < core_types_pkg::IQ_ENTRIES; s++) begin
			for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
				if (place_by_way[w] && slot_by_way[w] == core_types_pkg::iq_count_t'(s)) begin
					new_entry_by_slot[s] = entry_by_way[w];
				end
			end
		end
	end

endmodule

/* alu_reg_iq_select.sv */
// ALU issue queue select
// Picks the oldest entry whose operands are ready or waking now, and builds
// the issue record and the register-file read request for it
`timescale 1ns/1ps

module alu_reg_iq_select (
	input core_types_pkg::iq_entry_t [core_types_pkg::IQ_ENTRIES-1:0] entries,
	input logic [core_types_pkg::IQ_ENTRIES-1:0] A_wake_by_entry,
	input logic [core_types_pkg::IQ_ENTRIES-1:0] B_wake_by_entry,
	input logic pipeline_ready,
	output logic issue_fire,
	output logic [core_types_pkg::LOG_IQ_ENTRIES-1:0] issue_index,
	output core_types_pkg::alu_issue_t issue,
	output core_types_pkg::prf_req_t PRF_req
);

	logic [core_types_pkg::IQ_ENTRIES-1:0] issuable;
	core_types_pkg::iq_entry_t sel_entry;
	logic A_forward;
	logic B_forward;

	always_comb begin
		for (int e = 0; e < core_types_pkg::IQ_ENTRIES; e++) begin
			issuable[e] = entries[e].valid
				& (entries[e].A_ready | A_wake_by_entry[e])
				& (entries[e].B_ready | B_wake_by_entry[e]);
		end
	end

	// Priority encoder, lowest index is oldest
	always_comb begin
		issue_index = '0;
		for (int e = core_types_pkg::IQ_ENTRIES - 1; e >= 0; e--) begin
			if (issuable[e]) begin
				issue_index = (core_types_pkg::LOG_IQ_ENTRIES)'(e);
			end
		end
	end

	assign issue_fire = pipeline_ready & (|issuable);
	assign sel_entry = entries[issue_index];

	// Stored-ready operands read the PRF, freshly woken ones forward
	assign A_forward = ~sel_entry.A_ready & A_wake_by_entry[issue_index];
	assign B_forward = ~sel_entry.B_ready & B_wake_by_entry[issue_index];

	// ----------------------------------------
	// Issue record
	always_comb begin
		issue.valid = issue_fire;
		issue.op = sel_entry.op;
		issue.A_forward = A_forward;
		issue.A_bank = sel_entry.A_PR[core_types_pkg::LOG_PRF_BANK_COUNT-1:0];
		issue.B_forward = B_forward;
		issue.B_bank = sel_entry.B_PR[core_types_pkg::LOG_PRF_BANK_COUNT-1:0];
		issue.dest_PR = sel_entry.dest_PR;
		issue.ROB_index = sel_entry.ROB_index;
	end

	// ----------------------------------------
	// Register read request
	always_comb begin
		PRF_req.A_valid = issue_fire & ~A_forward;
		PRF_req.A_PR = sel_entry.A_PR;
		PRF_req.B_valid = issue_fire & ~B_forward;
		PRF_req.B_PR = sel_entry.B_PR;
	end

endmodule

/* alu_reg_iq_wrapper.sv */
// ALU issue queue top level
// Registers every input and every output of the issue queue so the queue
// sits between two register stages
`timescale 1ns/1ps

module alu_reg_iq_wrapper (
	input logic CLK,
	input logic nRST,

	// Dispatch by way
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] next_dispatch_attempt_by_way,
	input core_types_pkg::alu_dispatch_t [core_types_pkg::DISPATCH_WAYS-1:0]
		next_dispatch_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] last_dispatch_ready_by_way,

	// ALU pipeline feedback
	input logic next_pipeline_ready,

	// Writeback bus by bank
	input logic [core_types_pkg::PRF_BANK_COUNT-1:0] next_WB_bus_valid_by_bank,
	input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
		next_WB_bus_upper_PR_by_bank,

	// Issue and register read
	output core_types_pkg::alu_issue_t last_issue,
	output core_types_pkg::prf_req_t last_PRF_req
);

	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way;
	core_types_pkg::alu_dispatch_t [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_by_way;
	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_ready_by_way;
	logic pipeline_ready;
	logic [core_types_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
	core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank;
	core_types_pkg::alu_issue_t issue;
	core_types_pkg::prf_req_t PRF_req;

	alu_reg_iq alu_reg_iq_i (
		.CLK(CLK),
		.nRST(nRST),
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_by_way(dispatch_by_way),
		.dispatch_ready_by_way(dispatch_ready_by_way),
		.pipeline_ready(pipeline_ready),
		.WB_bus_valid_by_bank(WB_bus_valid_by_bank),
		.WB_bus_upper_PR_by_bank(WB_bus_upper_PR_by_bank),
		.issue(issue),
		.PRF_req(PRF_req)
	);

	// ----------------------------------------
	// Input and output stages
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			dispatch_attempt_by_way <= '0;
			dispatch_by_way <= '0;
			pipeline_ready <= 1'b0;
			WB_bus_valid_by_bank <= '0;
			WB_bus_upper_PR_by_bank <= '0;
			last_dispatch_ready_by_way <= '0;
			last_issue <= '0;
			last_PRF_req <= '0;
		end else begin
			dispatch_attempt_by_way <= next_dispatch_attempt_by_way;
			dispatch_by_way <= next_dispatch_by_way;
			pipeline_ready <= next_pipeline_ready;
			WB_bus_valid_by_bank <= next_WB_bus_valid_by_bank;
			WB_bus_upper_PR_by_bank <= next_WB_bus_upper_PR_by_bank;
			last_dispatch_ready_by_way <= dispatch_ready_by_way;
			last_issue <= issue;
			last_PRF_req <= PRF_req;
		end
	end

endmodule

/* core_types_pkg.sv */
// Core types package
// Sizes of the out-of-order core and the packed records exchanged between
// dispatch, the ALU register-register issue queue and the register file
package core_types_pkg;

	// ----------------------------------------
	// Core sizes
	localparam int DISPATCH_WAYS = 4;
	localparam int IQ_ENTRIES = 8;
	localparam int LOG_IQ_ENTRIES = 3;
	localparam int PR_COUNT = 64;
	localparam int LOG_PR_COUNT = 6;
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	localparam int ROB_ENTRIES = 64;
	localparam int LOG_ROB_ENTRIES = 6;

	// ----------------------------------------
	// Vector types
	// Low LOG_PRF_BANK_COUNT bits of a PR select the bank
	typedef logic [LOG_PR_COUNT-1:0] pr_t;
	typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
	typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
	typedef logic [3:0] alu_op_t;
	// Counts 0 to IQ_ENTRIES inclusive
	typedef logic [LOG_IQ_ENTRIES:0] iq_count_t;

	// ----------------------------------------
	// Records
	typedef struct packed {
		logic valid;
		alu_op_t op;
		pr_t A_PR;
		logic A_ready;
		pr_t B_PR;
		logic B_ready;
		pr_t dest_PR;
		rob_index_t ROB_index;
	} alu_dispatch_t;

	typedef struct packed {
		logic valid;
		alu_op_t op;
		logic A_forward;
		bank_t A_bank;
		logic B_forward;
		bank_t B_bank;
		pr_t dest_PR;
		rob_index_t ROB_index;
	} alu_issue_t;

	typedef struct packed {
		logic A_valid;
		pr_t A_PR;
		logic B_valid;
		pr_t B_PR;
	} prf_req_t;

	// One stored queue entry
	typedef struct packed {
		logic valid;
		alu_op_t op;
		pr_t A_PR;
		logic A_ready;
		pr_t B_PR;
		logic B_ready;
		pr_t dest_PR;
		rob_index_t ROB_index;
	} iq_entry_t;

endpackage

/* list.f */
core_types_pkg.sv
alu_reg_iq_dispatch.sv
alu_reg_iq_select.sv
alu_reg_iq.sv
alu_reg_iq_wrapper.sv
tb_alu_reg_iq_assert.sv
tb_alu_reg_iq.sv

/* tb_alu_reg_iq.sv */
// ALU issue queue testbench
// Drives dispatch bursts, writeback broadcasts and pipeline stalls into the
// wrapper and checks its outputs against a cycle model of the issue queue
`timescale 1ns/1ps

module tb_alu_reg_iq;

	localparam int MAX_OPS = 60;
	localparam int CYCLE_LIMIT = 2000;

	logic CLK;
	logic nRST;
	logic [3:0] next_dispatch_attempt_by_way;
	core_types_pkg::alu_dispatch_t [3:0] next_dispatch_by_way;
	logic next_pipeline_ready;
	logic [3:0] next_WB_bus_valid_by_bank;
	core_types_pkg::upper_pr_t [3:0] next_WB_bus_upper_PR_by_bank;
	logic [3:0] last_dispatch_ready_by_way;
	core_types_pkg::alu_issue_t last_issue;
	core_types_pkg::prf_req_t last_PRF_req;

	int seed;
	int errors;
	int assert_fails;
	int cycles;
	int dispatched;
	int issued;
	bit bcast_en;
	bit stall_en;
	bit seen [64];
	core_types_pkg::pr_t pending [$];

	// Model of the queue and of the wrapper input stage
	core_types_pkg::alu_dispatch_t model_q [$];
	logic [3:0] in_attempt;
	core_types_pkg::alu_dispatch_t [3:0] in_disp;
	logic in_pipe;
	logic [3:0] in_wb_valid;
	core_types_pkg::upper_pr_t [3:0] in_wb_upper;
	core_types_pkg::alu_issue_t exp_issue;
	core_types_pkg::prf_req_t exp_prf;
	logic [3:0] exp_ready;

	alu_reg_iq_wrapper dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, %0d of %0d ops issued",
				cycles, issued, dispatched);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic compare(input string name, input int expv, input int actv);
		if (expv != actv) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0h actual %0h",
				$time, name, expv, actv);
		end
	endtask

	// True when the writeback bus seen by the queue carries pr
	function automatic bit woken(input core_types_pkg::pr_t pr);
		return in_wb_valid[pr[1:0]] && (in_wb_upper[pr[1:0]] == pr[5:2]);
	endfunction

	// ----------------------------------------
	// Cycle model of the queue behind the input stage
	always @(posedge CLK) begin
		core_types_pkg::alu_dispatch_t e;
		int pick;
		bit a_wake;
		bit b_wake;
		exp_issue = '0;
		exp_prf = '0;
		exp_ready = '0;
		pick = -1;
		if (!nRST) begin
			model_q.delete();
			in_attempt = '0;
			in_disp = '0;
			in_pipe = 1'b0;
			in_wb_valid = '0;
			in_wb_upper = '0;
		end else begin
			// Ready bit w needs more than w free entries
			for (int w = 0; w < 4; w++)
				exp_ready[w] = (8 - model_q.size()) > w;
			for (int k = 0; k < model_q.size(); k++) begin
				e = model_q[k];
				a_wake = woken(e.A_PR);
				b_wake = woken(e.B_PR);
				if (in_pipe && pick < 0
					&& (e.A_ready || a_wake) && (e.B_ready || b_wake)) begin
					pick = k;
					exp_issue.valid = 1'b1;
					exp_issue.op = e.op;
					exp_issue.A_forward = !e.A_ready;
					exp_issue.A_bank = e.A_PR[1:0];
					exp_issue.B_forward = !e.B_ready;
					exp_issue.B_bank = e.B_PR[1:0];
					exp_issue.dest_PR = e.dest_PR;
					exp_issue.ROB_index = e.ROB_index;
					exp_prf.A_valid = e.A_ready;
					exp_prf.A_PR = e.A_PR;
					exp_prf.B_valid = e.B_ready;
					exp_prf.B_PR = e.B_PR;
				end
				e.A_ready = e.A_ready || a_wake;
				e.B_ready = e.B_ready || b_wake;
				model_q[k] = e;
			end
			if (pick >= 0)
				model_q.delete(pick);
			// Accepted ways append in way order
			for (int w = 0; w < 4; w++) begin
				if (in_disp[w].valid && in_attempt[w] && exp_ready[w]) begin
					e = in_disp[w];
					e.A_ready = e.A_ready || woken(e.A_PR);
					e.B_ready = e.B_ready || woken(e.B_PR);
					model_q.push_back(e);
				end
			end
			in_attempt = next_dispatch_attempt_by_way;
			in_disp = next_dispatch_by_way;
			in_pipe = next_pipeline_ready;
			in_wb_valid = next_WB_bus_valid_by_bank;
			in_wb_upper = next_WB_bus_upper_PR_by_bank;
		end
	end

	// Output checks, sampled away from the active clock edge
	always @(negedge CLK) begin
		compare("last_dispatch_ready_by_way", int'(exp_ready),
			int'(last_dispatch_ready_by_way));
		compare("last_issue.valid", int'(exp_issue.valid), int'(last_issue.valid));
		compare("last_PRF_req.A_valid", int'(exp_prf.A_valid), int'(last_PRF_req.A_valid));
		compare("last_PRF_req.B_valid", int'(exp_prf.B_valid), int'(last_PRF_req.B_valid));
		if (exp_issue.valid) begin
			compare("last_issue.op", int'(exp_issue.op), int'(last_issue.op));
			compare("last_issue.A_forward", int'(exp_issue.A_forward),
				int'(last_issue.A_forward));
			compare("last_issue.B_forward", int'(exp_issue.B_forward),
				int'(last_issue.B_forward));
			compare("last_issue.dest_PR", int'(exp_issue.dest_PR), int'(last_issue.dest_PR));
			compare("last_issue.ROB_index", int'(exp_issue.ROB_index),
				int'(last_issue.ROB_index));
		end
		if (exp_issue.A_forward)
			compare("last_issue.A_bank", int'(exp_issue.A_bank), int'(last_issue.A_bank));
		if (exp_issue.B_forward)
			compare("last_issue.B_bank", int'(exp_issue.B_bank), int'(last_issue.B_bank));
		if (exp_prf.A_valid)
			compare("last_PRF_req.A_PR", int'(exp_prf.A_PR), int'(last_PRF_req.A_PR));
		if (exp_prf.B_valid)
			compare("last_PRF_req.B_PR", int'(exp_prf.B_PR), int'(last_PRF_req.B_PR));
		if (nRST && last_issue.valid) begin
			if (seen[last_issue.ROB_index]) begin
				errors++;
				$display("ROB index %0d issued more than once at %0t",
					last_issue.ROB_index, $time);
			end
			seen[last_issue.ROB_index] = 1'b1;
			issued++;
		end
	end

	// ----------------------------------------
	// Stimulus tasks
	task automatic drive_common();
		core_types_pkg::pr_t pr;
		next_WB_bus_valid_by_bank = '0;
		next_pipeline_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
		if (bcast_en && pending.size() > 0) begin
			pr = pending.pop_front();
			next_WB_bus_valid_by_bank[pr[1:0]] = 1'b1;
			next_WB_bus_upper_PR_by_bank[pr[1:0]] = pr[5:2];
		end
	endtask

	task automatic idle();
		@(posedge CLK);
		#1;
		next_dispatch_attempt_by_way = '0;
		next_dispatch_by_way = '0;
		drive_common();
	endtask

	// mode 0 all ready, 1 A never ready, 2 random readiness
	task automatic burst(input int mode, input bit all_valid);
		logic [3:0] rdy;
		core_types_pkg::alu_dispatch_t d;
		@(posedge CLK);
		#1;
		drive_common();
		rdy = last_dispatch_ready_by_way;
		next_dispatch_attempt_by_way = rdy;
		for (int w = 0; w < 4; w++) begin
			d = '0;
			if (rdy[w] && dispatched < MAX_OPS
				&& (all_valid || ($random(seed) & 3) != 0)) begin
				d.valid = 1'b1;
				d.op = core_types_pkg::alu_op_t'($random(seed));
				d.A_PR = core_types_pkg::pr_t'($random(seed));
				d.B_PR = core_types_pkg::pr_t'($random(seed));
				d.dest_PR = core_types_pkg::pr_t'($random(seed));
				d.ROB_index = core_types_pkg::rob_index_t'(dispatched);
				d.A_ready = (mode == 0) || (mode == 2 && ($random(seed) & 1));
				d.B_ready = (mode != 2) || ($random(seed) & 1);
				if (!d.A_ready)
					pending.push_back(d.A_PR);
				if (!d.B_ready)
					pending.push_back(d.B_PR);
				dispatched++;
			end
			next_dispatch_by_way[w] = d;
		end
		idle();
		idle();
	endtask

	task automatic drain();
		while (issued != dispatched || pending.size() > 0)
			idle();
		repeat (4) idle();
	endtask

	initial begin
		seed = 32'h5d120745;
		nRST = 1'b0;
		next_dispatch_attempt_by_way = '0;
		next_dispatch_by_way = '0;
		next_pipeline_ready = 1'b0;
		next_WB_bus_valid_by_bank = '0;
		next_WB_bus_upper_PR_by_bank = '0;
		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;
		next_pipeline_ready = 1'b1;
		// In-order issue of ready ops
		repeat (3) burst(0, 1'b0);
		drain();
		// Fill with waiting ops, then wake them
		repeat (2) burst(1, 1'b1);
		repeat (2) idle();
		compare("last_dispatch_ready_by_way", 0, int'(last_dispatch_ready_by_way));
		bcast_en = 1'b1;
		drain();
		// Random readiness and stalls
		stall_en = 1'b1;
		repeat (12) burst(2, 1'b0);
		stall_en = 1'b0;
		drain();
		for (int r = 0; r < dispatched; r++) begin
			if (!seen[r]) begin
				errors++;
				$display("ROB index %0d was dispatched but never issued", r);
			end
		end
		assert_fails = dut_i.wrapper_chk_i.fail_count
			+ dut_i.alu_reg_iq_i.queue_chk_i.fail_count;
		$display("Check errors: %0d, assertion failures: %0d, dispatched: %0d, issued: %0d",
			errors, assert_fails, dispatched, issued);
		if (errors == 0 && assert_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* tb_alu_reg_iq_assert.sv */
// Issue queue protocol checks
// Bound to the wrapper and to the inner queue
`timescale 1ns/1ps

module tb_alu_reg_iq_assert (
	input logic CLK,
	input logic nRST,
	input logic zero_in_reset,
	input logic gate_delayed,
	input logic pipeline_ready,
	input core_types_pkg::alu_issue_t issue,
	input core_types_pkg::prf_req_t prf,
	input logic [3:0] ready_by_way,
	input logic [3:0] disp_valid
);

	int fail_count = 0;

	// Registered outputs clear during reset
	assert property (@(posedge CLK) (!nRST && zero_in_reset) |->
		(issue == '0 && prf == '0 && ready_by_way == '0))
		else begin
			$error("output not cleared in reset");
			fail_count++;
		end

	assert property (@(posedge CLK) disable iff (!nRST)
		issue.valid |-> (gate_delayed ? $past(pipeline_ready) : pipeline_ready))
		else begin
			$error("issue without pipeline ready");
			fail_count++;
		end

	assert property (@(posedge CLK) disable iff (!nRST)
		!(issue.A_forward && prf.A_valid) && !(issue.B_forward && prf.B_valid))
		else begin
			$error("forward and register read both set");
			fail_count++;
		end

	assert property (@(posedge CLK) disable iff (!nRST)
		(prf.A_valid || prf.B_valid) |-> issue.valid)
		else begin
			$error("register read without issue");
			fail_count++;
		end

	assert property (@(posedge CLK) disable iff (!nRST)
		(disp_valid & ~ready_by_way) == '0)
		else begin
			$error("valid dispatch on a way that is not ready");
			fail_count++;
		end

endmodule

bind alu_reg_iq_wrapper tb_alu_reg_iq_assert wrapper_chk_i (
	.CLK(CLK),
	.nRST(nRST),
	.zero_in_reset(1'b1),
	.gate_delayed(1'b1),
	.pipeline_ready(pipeline_ready),
	.issue(last_issue),
	.prf(last_PRF_req),
	.ready_by_way(last_dispatch_ready_by_way),
	.disp_valid({next_dispatch_by_way[3].valid, next_dispatch_by_way[2].valid,
		next_dispatch_by_way[1].valid, next_dispatch_by_way[0].valid})
);

bind alu_reg_iq tb_alu_reg_iq_assert queue_chk_i (
	.CLK(CLK),
	.nRST(nRST),
	.zero_in_reset(1'b0),
	.gate_delayed(1'b0),
	.pipeline_ready(pipeline_ready),
	.issue(issue),
	.prf(PRF_req),
	.ready_by_way(dispatch_ready_by_way),
	.disp_valid({dispatch_by_way[3].valid, dispatch_by_way[2].valid,
		dispatch_by_way[1].valid, dispatch_by_way[0].valid})
);
